// File: filelist.f
+incdir+verification
source/radio_pkg.sv
source/sample_fifo.sv
source/fir_decimator.sv
source/stereo_matrix.sv
source/audio_backend_top.sv
verification/audio_backend_tb.sv

// File: verification/audio_backend_tests.svh
// reset every stage and restart the model
task automatic reset_dut();
    @(negedge clock);
    arst_n = 1'b0;
    in_valid = 1'b0;
    out_ready = 1'b0;
    repeat (4) @(negedge clock);
    arst_n = 1'b1;
    for (int i = 0; i < TAPS; i++) begin
        hist_lpr[i] = '0;
        hist_lmr[i] = '0;
    end
    accepted_cnt = 0;
    expect_q.delete();
endtask

// small amplitude keeps the matrix sums well inside 32 bits
function automatic radio_pkg::sample_pair_t random_pair();
    radio_pkg::sample_pair_t pair;
    pair.lpr = $random(seed) % 4096;
    pair.lmr = $random(seed) % 4096;
    return pair;
endfunction

task automatic test_reset_state();
    int start_failures;
    start_failures = failures;
    test_name = "reset state";
    for (int i = 0; i < 6; i++) begin
        @(negedge clock);
        // released on the fourth falling edge
        arst_n = (i >= 3);
        check_flag("reset state out_valid", 1'b0, out_valid);
        check_flag("reset state in_ready", 1'b1, in_ready);
    end
    finish_test(start_failures);
endtask

task automatic test_impulse_response();
    int start_failures;
    radio_pkg::sample_pair_t pair;
    start_failures = failures;
    test_name = "impulse response";
    reset_dut();
    for (int i = 0; i < DECIMATION * TAPS; i++) begin
        pair = '0;
        if (i == 0) begin
            pair.lpr = 32'sd1024;
            pair.lmr = 32'sd512;
        end
        stim_q.push_back(pair);
    end
    run_stream(0);
    finish_test(start_failures);
endtask

task automatic test_random_stream();
    int start_failures;
    start_failures = failures;
    test_name = "random stream";
    reset_dut();
    repeat (64) stim_q.push_back(random_pair());
    run_stream(0);
    finish_test(start_failures);
endtask

task automatic test_decimation_count();
    int start_failures;
    int start_outputs;
    int seen;
    start_failures = failures;
    start_outputs = outputs_seen;
    test_name = "decimation count";
    reset_dut();
    repeat (5 * DECIMATION) stim_q.push_back(random_pair());
    run_stream(0);
    seen = outputs_seen - start_outputs;
    check_flag($sformatf("decimation count, %0d outputs where 5 were due", seen),
               1'b1, seen == 5);
    // the pipeline is drained, nothing more may come out
    repeat (4 * TAPS) begin
        @(negedge clock);
        check_flag("decimation count out_valid after drain", 1'b0, out_valid);
    end
    finish_test(start_failures);
endtask

task automatic test_back_pressure();
    int start_failures;
    start_failures = failures;
    test_name = "back-pressure";
    reset_dut();
    stall_seen = 1'b0;
    repeat (30 * DECIMATION) stim_q.push_back(random_pair());
    run_stream(1);
    check_flag("back-pressure in_ready fell", 1'b1, stall_seen);
    finish_test(start_failures);
endtask

// File: verification/audio_backend_tb.sv
`timescale 1ns/1ns

module audio_backend_tb;

    localparam int TAPS = radio_pkg::DEFAULT_TAPS;
    localparam int DECIMATION = radio_pkg::DEFAULT_DECIMATION;
    localparam int GAIN_SHIFT = radio_pkg::DEFAULT_GAIN_SHIFT;
    localparam int STREAM_LIMIT = 10000;

    logic clock;
    logic arst_n;
    radio_pkg::sample_pair_t in_data;
    logic in_valid;
    logic in_ready;
    radio_pkg::stereo_t out_data;
    logic out_valid;
    logic out_ready;

    // model history, newest sample at index 0
    radio_pkg::sample_t hist_lpr [TAPS];
    radio_pkg::sample_t hist_lmr [TAPS];
    int accepted_cnt;
    radio_pkg::sample_pair_t stim_q [$];
    radio_pkg::stereo_t expect_q [$];
    int seed;
    int checks;
    int failures;
    int outputs_seen;
    bit aborted;
    bit stall_seen;
    string test_name;

    audio_backend_top #(
        .TAPS(TAPS),
        .DECIMATION(DECIMATION),
        .FIFO_DEPTH(radio_pkg::DEFAULT_FIFO_DEPTH),
        .GAIN_SHIFT(GAIN_SHIFT)
    ) dut (.*);

    always #10 clock = ~clock;

    task automatic check_stereo(input string name, input radio_pkg::stereo_t expected,
                                input radio_pkg::stereo_t actual);
        checks++;
        if (actual !== expected) begin
            failures++;
            $display("Fail %s expected left %0d right %0d actual left %0d right %0d",
                     name, expected.left, expected.right, actual.left, actual.right);
        end
    endtask

    task automatic check_flag(input string name, input logic expected, input logic actual);
        checks++;
        if (actual !== expected) begin
            failures++;
            $display("Fail %s expected %b actual %b", name, expected, actual);
        end
    endtask

    // every accepted pair enters the history, each DECIMATION-th one yields an output
    task automatic model_accept(input radio_pkg::sample_pair_t pair);
        logic signed [79:0] acc_lpr;
        logic signed [79:0] acc_lmr;
        radio_pkg::sample_t lpr;
        radio_pkg::sample_t lmr;
        radio_pkg::stereo_t mixed;
        for (int i = TAPS - 1; i > 0; i--) begin
            hist_lpr[i] = hist_lpr[i-1];
            hist_lmr[i] = hist_lmr[i-1];
        end
        hist_lpr[0] = pair.lpr;
        hist_lmr[0] = pair.lmr;
        accepted_cnt++;
        if (accepted_cnt % DECIMATION == 0) begin
            acc_lpr = '0;
            acc_lmr = '0;
            for (int i = 0; i < TAPS; i++) begin
                acc_lpr = acc_lpr + hist_lpr[i] * radio_pkg::LPR_COEFFS[i];
                acc_lmr = acc_lmr + hist_lmr[i] * radio_pkg::LMR_COEFFS[i];
            end
            // back to Q10, cut to 32 bits
            lpr = radio_pkg::sample_t'(acc_lpr >>> radio_pkg::FRAC_BITS);
            lmr = radio_pkg::sample_t'(acc_lmr >>> radio_pkg::FRAC_BITS);
            mixed.left = radio_pkg::sample_t'(lpr + lmr) <<< GAIN_SHIFT;
            mixed.right = radio_pkg::sample_t'(lpr - lmr) <<< GAIN_SHIFT;
            expect_q.push_back(mixed);
        end
    endtask

    task automatic take_output();
        radio_pkg::stereo_t expected;
        if (expect_q.size() == 0) begin
            failures++;
            $display("%s: an output appeared that the model did not predict", test_name);
        end else begin
            expected = expect_q.pop_front();
            check_stereo($sformatf("%s output %0d", test_name, outputs_seen),
                         expected, out_data);
        end
        outputs_seen++;
    endtask

    // ready_mode 0 keeps out_ready high
    // ready_mode 1 stalls the reader until in_ready falls, then toggles out_ready
    task automatic run_stream(input int ready_mode);
        radio_pkg::sample_pair_t cur;
        bit have_cur;
        int cycles;
        int rnd;
        have_cur = 1'b0;
        cycles = 0;
        while ((have_cur || stim_q.size() > 0 || expect_q.size() > 0)
               && cycles < STREAM_LIMIT) begin
            @(negedge clock);
            cycles++;
            if (!have_cur && stim_q.size() > 0) begin
                cur = stim_q.pop_front();
                have_cur = 1'b1;
            end
            in_valid = have_cur;
            in_data = have_cur ? cur : '0;
            rnd = $random(seed);
            out_ready = (ready_mode == 0) || (stall_seen && rnd[0]);
            if (!in_ready) begin
                stall_seen = 1'b1;
            end
            // both handshakes complete on the coming rising edge
            if (have_cur && in_ready) begin
                model_accept(cur);
                have_cur = 1'b0;
            end
            if (out_valid && out_ready) begin
                take_output();
            end
        end
        if (have_cur || stim_q.size() > 0) begin
            $display("%s: timeout, in_ready never returned high", test_name);
            aborted = 1'b1;
        end else if (expect_q.size() > 0) begin
            $display("%s: timeout, out_valid never arrived for %0d outputs",
                     test_name, expect_q.size());
            aborted = 1'b1;
        end
        @(negedge clock);
        in_valid = 1'b0;
    endtask

    task automatic finish_test(input int start_failures);
        $display("%s: finished, %0d mismatches", test_name, failures - start_failures);
    endtask

    `include "audio_backend_tests.svh"

    initial begin
        clock = 1'b0;
        arst_n = 1'b0;
        in_data = '0;
        in_valid = 1'b0;
        out_ready = 1'b0;
        seed = 46;
        checks = 0;
        failures = 0;
        outputs_seen = 0;
        accepted_cnt = 0;
        aborted = 1'b0;
        stall_seen = 1'b0;
        test_reset_state();
        if (!aborted) test_impulse_response();
        if (!aborted) test_random_stream();
        if (!aborted) test_decimation_count();
        if (!aborted) test_back_pressure();
        $display("checks %0d, mismatches %0d, aborted %0d", checks, failures, aborted);
        if (failures == 0 && !aborted) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// File: source/audio_backend_top.sv
`timescale 1ns/1ns

module audio_backend_top #(
    parameter int TAPS = radio_pkg::DEFAULT_TAPS,
    parameter int DECIMATION = radio_pkg::DEFAULT_DECIMATION,
    parameter int FIFO_DEPTH = radio_pkg::DEFAULT_FIFO_DEPTH,
    parameter int GAIN_SHIFT = radio_pkg::DEFAULT_GAIN_SHIFT
) (
    input  logic                    clock,
    input  logic                    arst_n,
    input  radio_pkg::sample_pair_t in_data,
    input  logic                    in_valid,
    output logic                    in_ready,
    output radio_pkg::stereo_t      out_data,
    output logic                    out_valid,
    input  logic                    out_ready
);

    // input FIFO to FIR
    radio_pkg::sample_pair_t raw_data;
    logic raw_valid;
    logic raw_ready;

    // FIR to stereo matrix
    radio_pkg::sample_pair_t filt_data;
    logic filt_valid;
    logic filt_ready;

    // stereo matrix to output FIFO
    radio_pkg::stereo_t mix_data;
    logic mix_valid;
    logic mix_ready;

    sample_fifo #(
        .payload_t(radio_pkg::sample_pair_t),
        .DEPTH(FIFO_DEPTH)
    ) input_fifo (
        .clock(clock),
        .arst_n(arst_n),
        .in_data(in_data),
        .in_valid(in_valid),
        .in_ready(in_ready),
        .out_data(raw_data),
        .out_valid(raw_valid),
        .out_ready(raw_ready)
    );

    // both channels share one decimation phase
    fir_decimator #(
        .TAPS(TAPS),
        .DECIMATION(DECIMATION),
        .LPR_COEFF(radio_pkg::LPR_COEFFS),
        .LMR_COEFF(radio_pkg::LMR_COEFFS)
    ) fir (
        .clock(clock),
        .arst_n(arst_n),
        .in_data(raw_data),
        .in_valid(raw_valid),
        .in_ready(raw_ready),
        .out_data(filt_data),
        .out_valid(filt_valid),
        .out_ready(filt_ready)
    );

    stereo_matrix #(
        .GAIN_SHIFT(GAIN_SHIFT)
    ) matrix (
        .clock(clock),
        .arst_n(arst_n),
        .in_data(filt_data),
        .in_valid(filt_valid),
        .in_ready(filt_ready),
        .out_data(mix_data),
        .out_valid(mix_valid),
        .out_ready(mix_ready)
    );

    sample_fifo #(
        .payload_t(radio_pkg::stereo_t),
        .DEPTH(FIFO_DEPTH)
    ) output_fifo (
        .clock(clock),
        .arst_n(arst_n),
        .in_data(mix_data),
        .in_valid(mix_valid),
        .in_ready(mix_ready),
        .out_data(out_data),
        .out_valid(out_valid),
        .out_ready(out_ready)
    );

endmodule

// File: source/stereo_matrix.sv
`timescale 1ns/1ns

module stereo_matrix #(
    parameter int GAIN_SHIFT = radio_pkg::DEFAULT_GAIN_SHIFT
) (
    input  logic                    clock,
    input  logic                    arst_n,
    input  radio_pkg::sample_pair_t in_data,
    input  logic                    in_valid,
    output logic                    in_ready,
    output radio_pkg::stereo_t      out_data,
    output logic                    out_valid,
    input  logic                    out_ready
);

    radio_pkg::sample_t left_sum;
    radio_pkg::sample_t right_diff;
    logic in_fire;

    // (l+r) + (l-r) = 2l and (l+r) - (l-r) = 2r, both wrap at 32 bits
    assign left_sum = in_data.lpr + in_data.lmr;
    assign right_diff = in_data.lpr - in_data.lmr;

    // take a new pair when the register is free or being emptied now
    assign in_ready = !out_valid || out_ready;
    assign in_fire = in_valid && in_ready;

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            out_valid <= 1'b0;
        end else if (in_fire) begin
            out_valid <= 1'b1;
        end else if (out_ready) begin
            out_valid <= 1'b0;
        end
    end

    // output gain, shifted bits beyond 32 are lost
    always_ff @(posedge clock) begin
        if (in_fire) begin
            out_data.left <= left_sum <<< GAIN_SHIFT;
            out_data.right <= right_diff <<< GAIN_SHIFT;
        end
    end

    hold_until_taken: assert property (
        @(posedge clock) disable iff (!arst_n)
        out_valid && !out_ready |=> out_valid
    );

endmodule

// File: source/fir_decimator.sv
`timescale 1ns/1ns

module fir_decimator #(
    parameter int TAPS = radio_pkg::DEFAULT_TAPS,
    parameter int DECIMATION = radio_pkg::DEFAULT_DECIMATION,
    parameter radio_pkg::sample_t LPR_COEFF [TAPS] = radio_pkg::LPR_COEFFS,
    parameter radio_pkg::sample_t LMR_COEFF [TAPS] = radio_pkg::LMR_COEFFS
) (
    input  logic                    clock,
    input  logic                    arst_n,
    input  radio_pkg::sample_pair_t in_data,
    input  logic                    in_valid,
    output logic                    in_ready,
    output radio_pkg::sample_pair_t out_data,
    output logic                    out_valid,
    input  logic                    out_ready
);

    localparam int DEC_W = (DECIMATION > 1) ? $clog2(DECIMATION) : 1;
    localparam int TAP_W = (TAPS > 1) ? $clog2(TAPS) : 1;
    localparam int PROD_W = 2 * radio_pkg::SAMPLE_WIDTH;
    // headroom for the sum of TAPS full-width products
    localparam int ACC_W = PROD_W + TAP_W;

    typedef enum logic [1:0] {
        S_IDLE,
        S_MAC,
        S_OUT
    } state_t;

    state_t state;
    logic [DEC_W-1:0] dec_cnt;
    logic [TAP_W-1:0] tap_cnt;
    radio_pkg::sample_t delay_lpr [TAPS];
    radio_pkg::sample_t delay_lmr [TAPS];
    logic signed [ACC_W-1:0] acc_lpr;
    logic signed [ACC_W-1:0] acc_lmr;
    logic signed [PROD_W-1:0] prod_lpr;
    logic signed [PROD_W-1:0] prod_lmr;
    logic signed [ACC_W-1:0] sum_lpr;
    logic signed [ACC_W-1:0] sum_lmr;
    logic in_fire;
    logic last_tap;

    assign in_ready = (state == S_IDLE);
    assign out_valid = (state == S_OUT);
    assign in_fire = in_valid && in_ready;
    assign last_tap = (tap_cnt == TAP_W'(TAPS - 1));

    // one tap per cycle, both channels side by side
    assign prod_lpr = delay_lpr[tap_cnt] * LPR_COEFF[tap_cnt];
    assign prod_lmr = delay_lmr[tap_cnt] * LMR_COEFF[tap_cnt];
    assign sum_lpr = acc_lpr + prod_lpr;
    assign sum_lmr = acc_lmr + prod_lmr;

    // delay lines, newest sample at index 0
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < TAPS; i++) begin
                delay_lpr[i] <= '0;
                delay_lmr[i] <= '0;
            end
        end else if (in_fire) begin
            delay_lpr[0] <= in_data.lpr;
            delay_lmr[0] <= in_data.lmr;
            for (int i = 1; i < TAPS; i++) begin
                delay_lpr[i] <= delay_lpr[i-1];
                delay_lmr[i] <= delay_lmr[i-1];
            end
        end
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            state <= S_IDLE;
            dec_cnt <= '0;
            tap_cnt <= '0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (in_fire) begin
                        // only every DECIMATION-th pair starts a MAC pass
                        if (dec_cnt == DEC_W'(DECIMATION - 1)) begin
                            dec_cnt <= '0;
                            tap_cnt <= '0;
                            state <= S_MAC;
                        end else begin
                            dec_cnt <= dec_cnt + 1'b1;
                        end
                    end
                end
                S_MAC: begin
                    if (last_tap) begin
                        state <= S_OUT;
                    end else begin
                        tap_cnt <= tap_cnt + 1'b1;
                    end
                end
                S_OUT: begin
                    if (out_ready) begin
                        state <= S_IDLE;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (in_fire) begin
            acc_lpr <= '0;
            acc_lmr <= '0;
        end else if (state == S_MAC) begin
            acc_lpr <= sum_lpr;
            acc_lmr <= sum_lmr;
            if (last_tap) begin
                // back to Q10, upper bits dropped
                out_data.lpr <= radio_pkg::sample_t'(sum_lpr >>> radio_pkg::FRAC_BITS);
                out_data.lmr <= radio_pkg::sample_t'(sum_lmr >>> radio_pkg::FRAC_BITS);
            end
        end
    end

    // input stays blocked for the whole MAC pass, then the result is offered
    mac_blocks_input: assert property (
        @(posedge clock) disable iff (!arst_n)
        in_fire && dec_cnt == DEC_W'(DECIMATION - 1)
            |=> (!in_ready) [*TAPS] ##1 out_valid
    );

endmodule

// File: source/sample_fifo.sv
`timescale 1ns/1ns

module sample_fifo #(
    parameter type payload_t = logic [31:0],
    parameter int  DEPTH     = 16
) (
    input  logic     clock,
    input  logic     arst_n,
    input  payload_t in_data,
    input  logic     in_valid,
    output logic     in_ready,
    output payload_t out_data,
    output logic     out_valid,
    input  logic     out_ready
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    payload_t mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic wr_fire;
    logic rd_fire;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign out_valid = (count != '0);
    // a full buffer still takes a word when the head leaves in the same cycle
    assign in_ready = (count != CNT_W'(DEPTH)) || out_ready;
    assign wr_fire = in_valid && in_ready;
    assign rd_fire = out_valid && out_ready;

    // first word falls through, head is read straight from storage
    assign out_data = mem[rd_ptr];

    always_ff @(posedge clock) begin
        if (wr_fire) begin
            mem[wr_ptr] <= in_data;
        end
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (wr_fire) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (rd_fire) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({wr_fire, rd_fire})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    occupancy_bound: assert property (
        @(posedge clock) disable iff (!arst_n)
        count <= CNT_W'(DEPTH)
    );

    // a stalled head must not change under the reader
    head_hold: assert property (
        @(posedge clock) disable iff (!arst_n)
        out_valid && !out_ready |=> out_valid && $stable(out_data)
    );

endmodule

// File: source/radio_pkg.sv
package radio_pkg;

    // fixed-point format shared by every stage
    parameter int SAMPLE_WIDTH = 32;
    parameter int FRAC_BITS = 10;

    typedef logic signed [SAMPLE_WIDTH-1:0] sample_t;

    // demodulated baseband pair, sum and difference channel
    typedef struct packed {
        sample_t lpr;
        sample_t lmr;
    } sample_pair_t;

    // audio pair after the stereo matrix
    typedef struct packed {
        sample_t left;
        sample_t right;
    } stereo_t;

    // default sizes, taken over by the top level
    parameter int DEFAULT_TAPS = 8;
    parameter int DEFAULT_DECIMATION = 4;
    parameter int DEFAULT_FIFO_DEPTH = 16;
    parameter int DEFAULT_GAIN_SHIFT = 1;

    // low-pass taps in Q10, index 0 meets the newest sample
    // each set sums to 1024 so the pass band has unity gain
    parameter sample_t LPR_COEFFS [DEFAULT_TAPS] = '{
        32'sd20,
        32'sd64,
        32'sd144,
        32'sd284,
        32'sd284,
        32'sd144,
        32'sd64,
        32'sd20
    };

    // slightly sharper roll-off for the difference channel
    parameter sample_t LMR_COEFFS [DEFAULT_TAPS] = '{
        32'sd12,
        32'sd56,
        32'sd150,
        32'sd294,
        32'sd294,
        32'sd150,
        32'sd56,
        32'sd12
    };

endpackage
